// ==== sources.f ====
+incdir+design
design/mem_pkg.sv
design/access_align.sv
design/load_store_buffer.sv
design/sram_ctrl.sv
design/mem_subsystem.sv
verification/tb_mem_subsystem.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_mem_subsystem

all: run

# Rebuilt only when a source, a header or the file list changes.
$(SIM): sources.f $(wildcard design/*.sv design/*.svh verification/*.sv)
	verilator --binary --timing --assert --top-module tb_mem_subsystem -f sources.f

run: $(SIM) verification/mem_input.txt
	./$(SIM) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== verification/mem_input.txt ====
# Columns: opcode, byte address, store data, expected load data (all hex).
# Store rows carry 00000000 as the expected value.
sw 000 11223344 00000000
sw 004 a5a5f00f 00000000
sw 008 80007fff 00000000
lw 000 00000000 11223344
lw 004 00000000 a5a5f00f
lw 008 00000000 80007fff
sw 010 00000000 00000000
sb 010 123456aa 00000000
sb 013 ffffff81 00000000
sw 020 ffffffff 00000000
sh 020 abcd1234 00000000
sb 022 0000007e 00000000
sw 030 deadbeef 00000000
sh 032 0000c001 00000000
lw 010 00000000 810000aa
lw 020 00000000 ff7e1234
lw 030 00000000 c001beef
lb 010 00000000 ffffffaa
lbu 010 00000000 000000aa
lb 013 00000000 ffffff81
lbu 013 00000000 00000081
lb 001 00000000 00000033
lh 004 00000000 fffff00f
lhu 004 00000000 0000f00f
lh 006 00000000 ffffa5a5
lhu 00a 00000000 00008000
lb 022 00000000 0000007e
lhu 032 00000000 0000c001
sb 031 99999955 00000000
lw 030 00000000 c00155ef

// ==== verification/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int MAX_ACC = 64;
    localparam int TIMEOUT_CYCLES = 50 * (`LSB_DEPTH + `MEM_LATENCY);

    logic      clk = 1'b0;
    logic      resetn;
    cpu_req_t  cpu_req;
    cpu_resp_t cpu_resp;

    mem_op_e     acc_op    [MAX_ACC];
    logic [31:0] acc_addr  [MAX_ACC];
    logic [31:0] acc_wdata [MAX_ACC];
    logic [31:0] acc_exp   [MAX_ACC];
    int          acc_cycle [MAX_ACC];   // Cycle of acceptance.
    int          pending   [$];         // Accepted, not yet completed.

    int   n_acc;
    int   cur_idx;
    int   cycle;
    int   accept_count;
    int   done_count;
    int   errors;
    int   timeouts;
    logic timed_out;

    mem_subsystem DUT (
        .clk      (clk),
        .resetn   (resetn),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle = cycle + 1;

    function automatic logic is_store(input mem_op_e op);
        return op == op_sb || op == op_sh || op == op_sw;
    endfunction

    function automatic logic parse_op(input string name, output mem_op_e op);
        op = op_lw;
        if (name == "lb") op = op_lb;
        else if (name == "lh") op = op_lh;
        else if (name == "lw") op = op_lw;
        else if (name == "lbu") op = op_lbu;
        else if (name == "lhu") op = op_lhu;
        else if (name == "sb") op = op_sb;
        else if (name == "sh") op = op_sh;
        else if (name == "sw") op = op_sw;
        else return 1'b0;
        return 1'b1;
    endfunction

    task automatic load_input;
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        mem_op_e     op;
        fd = $fopen("verification/mem_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/mem_input.txt for reading.");
            errors++;
            return;
        end
        while (!$feof(fd) && n_acc < MAX_ACC) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#")
                continue;   // Blank or comment line.
            code = $sscanf(line, "%s %h %h %h", name, addr, wdata, exp_val);
            if (code != 4 || !parse_op(name, op)) begin
                $display("Malformed line in the input file: %s", line);
                errors++;
                continue;
            end
            acc_op[n_acc]    = op;
            acc_addr[n_acc]  = addr;
            acc_wdata[n_acc] = wdata;
            acc_exp[n_acc]   = exp_val;
            n_acc++;
        end
        $fclose(fd);
    endtask

    // Holds one access until addr_ok, then returns just after the accepting edge.
    task automatic issue_access(input int idx);
        int waited;
        cur_idx       = idx;
        cpu_req.valid = 1'b1;
        cpu_req.op    = acc_op[idx];
        cpu_req.addr  = acc_addr[idx];
        cpu_req.wdata = acc_wdata[idx];
        waited = 0;
        @(negedge clk);
        while (!cpu_resp.addr_ok && waited < TIMEOUT_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        if (!cpu_resp.addr_ok) begin
            $display("Access %0d was not accepted within %0d cycles.", idx, TIMEOUT_CYCLES);
            timeouts++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_completion;
        int idx;
        assert (pending.size() != 0) else begin
            errors++;
            $display("error at %0t: completion with no access outstanding", $time);
        end
        if (pending.size() != 0) begin
            idx = pending.pop_front();
            done_count++;
            if (is_store(acc_op[idx])) begin
                assert (acc_cycle[idx] == cycle) else begin
                    errors++;
                    $display("error at %0t: store %0d completed %0d cycles after acceptance",
                             $time, idx, cycle - acc_cycle[idx]);
                end
            end else begin
                assert (cpu_resp.rdata == acc_exp[idx]) else begin
                    errors++;
                    $display("error at %0t: load %0d at %h returned %h, expected %h",
                             $time, idx, acc_addr[idx], cpu_resp.rdata, acc_exp[idx]);
                end
            end
        end
    endtask

    // Sampled mid-cycle, where the handshake is settled.
    always @(negedge clk) begin
        if (resetn) begin
            assert (!cpu_resp.addr_ok && !cpu_resp.data_ok) else begin
                errors++;
                $display("error at %0t: addr_ok or data_ok high during reset", $time);
            end
        end else begin
            if (cpu_resp.addr_ok) begin
                assert (cpu_req.valid && cur_idx == accept_count) else begin
                    errors++;
                    $display("error at %0t: acceptance of access %0d out of sequence",
                             $time, cur_idx);
                end
                acc_cycle[cur_idx] = cycle;
                pending.push_back(cur_idx);
                accept_count++;
            end
            if (cpu_resp.data_ok)
                check_completion();
        end
    end

    initial begin : run_test
        int i;
        int waited;
        resetn       = 1'b1;
        cpu_req      = '0;
        cycle        = 0;
        n_acc        = 0;
        cur_idx      = 0;
        accept_count = 0;
        done_count   = 0;
        errors       = 0;
        timeouts     = 0;
        timed_out    = 1'b0;
        load_input();

        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b0;

        // Next access goes out right after acceptance, so loads pile up in flight.
        for (i = 0; i < n_acc && !timed_out; i++)
            issue_access(i);
        cpu_req = '0;

        waited = 0;
        while (done_count < accept_count && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (done_count < accept_count) begin
            $display("%0d accesses never completed.", accept_count - done_count);
            timeouts++;
        end
        repeat (2 * `MEM_LATENCY) @(posedge clk);   // Catches stray completions.

        assert (accept_count == n_acc && done_count == accept_count) else begin
            errors++;
            $display("error at %0t: %0d of %0d accesses accepted, %0d completed",
                     $time, accept_count, n_acc, done_count);
        end

        $display("Summary: %0d check errors, %0d timeouts, %0d accepted, %0d completed",
                 errors, timeouts, accept_count, done_count);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end
endmodule

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic               clk,
    input  logic               resetn,
    input  mem_pkg::cpu_req_t  cpu_req,
    output mem_pkg::cpu_resp_t cpu_resp
);
    import mem_pkg::*;

    sramx_req_t  al_req;     // Aligner to buffer.
    sramx_resp_t al_resp;
    sramx_req_t  mem_req;    // Buffer to SRAM.
    sramx_resp_t mem_resp;

    access_align u_align (
        .clk      (clk),
        .resetn   (resetn),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .s_req    (al_req),
        .s_resp   (al_resp)
    );

    load_store_buffer u_lsb (
        .clk    (clk),
        .resetn (resetn),
        .m_req  (al_req),
        .m_resp (al_resp),
        .s_req  (mem_req),
        .s_resp (mem_resp)
    );

    sram_ctrl u_sram (
        .clk    (clk),
        .resetn (resetn),
        .req    (mem_req),
        .resp   (mem_resp)
    );
endmodule

// ==== design/sram_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  mem_pkg::sramx_req_t  req,
    output mem_pkg::sramx_resp_t resp
);
    import mem_pkg::*;

    localparam int LAT = `MEM_LATENCY;
    localparam int CW  = $clog2(LAT + 1);

    logic [31:0]    mem [`MEM_WORDS];
    logic [LAT-1:0] vld_q;      // Response pipeline valid bits.
    logic [31:0]    rd_q [LAT];
    logic [CW-1:0]  inflight;
    word_addr_t     idx;
    logic           accept;

    assign idx    = req.addr[2 +: $bits(word_addr_t)];
    assign accept = req.req && resp.addr_ok;

    always_comb begin
        resp.addr_ok = (inflight < CW'(LAT));
        resp.data_ok = vld_q[LAT-1];
        resp.rdata   = rd_q[LAT-1];
    end

    // Byte-strobed write at acceptance.
    always_ff @(posedge clk) begin
        if (accept && req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0] <= mem[idx];   // Sampled before any same-cycle write.
        for (int k = 1; k < LAT; k++)
            rd_q[k] <= rd_q[k-1];
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            vld_q    <= '0;
            inflight <= '0;
        end else begin
            vld_q[0] <= accept;
            for (int k = 1; k < LAT; k++)
                vld_q[k] <= vld_q[k-1];
            inflight <= inflight + CW'(accept) - CW'(resp.data_ok);
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (resetn)
        req.req |-> (req.addr[31:2] < `MEM_WORDS));
endmodule

// ==== design/load_store_buffer.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module load_store_buffer (
    input  logic                 clk,
    input  logic                 resetn,
    input  mem_pkg::sramx_req_t  m_req,
    output mem_pkg::sramx_resp_t m_resp,
    output mem_pkg::sramx_req_t  s_req,
    input  mem_pkg::sramx_resp_t s_resp
);
    import mem_pkg::*;

    localparam int DEPTH = `LSB_DEPTH;
    localparam int IW    = $clog2(DEPTH);

    typedef logic [IW-1:0] index_t;

    sramx_req_t       fifo [DEPTH];
    logic [DEPTH-1:0] free_q;   // One bit per entry, set when free.
    index_t           head;
    index_t           tail;
    lsb_state_e       state;

    sramx_req_t tail_elem;
    index_t     tail_nxt;
    logic       fifo_empty;
    logic       fifo_avail;
    logic       kind_ok;
    logic       req_ff_ok;
    logic       fifo_push;
    logic       fifo_pop;
    logic       s_accept;

    assign tail_elem  = fifo[tail];
    assign tail_nxt   = index_t'(tail + 1'b1);
    assign fifo_empty = free_q[tail];
    assign fifo_avail = free_q[head];
    assign kind_ok    = (state == lsb_idle) || (m_req.wr == (state == lsb_stores));
    assign req_ff_ok  = m_req.req && fifo_empty && s_resp.data_ok;   // Fast-forward.
    assign fifo_push  = m_req.req && fifo_avail && kind_ok && !req_ff_ok;
    assign fifo_pop   = !fifo_empty && s_resp.data_ok;
    assign s_accept   = s_req.req && s_resp.addr_ok;

    always_ff @(posedge clk) begin
        if (resetn) begin
            head   <= '0;
            tail   <= '0;
            free_q <= '1;
            state  <= lsb_idle;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (fifo_push && head == index_t'(i))
                    free_q[i] <= 1'b0;
                else if (fifo_pop && tail == index_t'(i))
                    free_q[i] <= 1'b1;
            end

            if (fifo_push)
                head <= index_t'(head + 1'b1);
            if (fifo_pop)
                tail <= tail_nxt;

            // Last entry leaving returns the buffer to idle.
            if (fifo_push)
                state <= m_req.wr ? lsb_stores : lsb_loads;
            else if (fifo_pop && free_q[tail_nxt])
                state <= lsb_idle;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (fifo_push && head == index_t'(i)) begin
                fifo[i]     <= m_req;
                fifo[i].req <= !(fifo_empty && s_resp.addr_ok);   // Already sent on bypass.
            end else if (s_accept && tail == index_t'(i)) begin
                fifo[i].req <= 1'b0;
            end
        end
    end

    always_comb begin
        m_resp.addr_ok = fifo_push || req_ff_ok;
        m_resp.data_ok = req_ff_ok
                      || (fifo_push && m_req.wr)
                      || (state == lsb_loads && s_resp.data_ok);
        m_resp.rdata   = s_resp.rdata;
    end

    assign s_req = fifo_empty ? m_req : tail_elem;

    // A full queue has its pointers met.
    a_no_push_full: assert property (@(posedge clk) disable iff (resetn)
        (free_q == '0) |-> (head == tail) && !m_resp.addr_ok);

    // Downstream only answers what was queued.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (resetn)
        s_resp.data_ok |-> !fifo_empty || req_ff_ok);

    a_mode_idle: assert property (@(posedge clk) disable iff (resetn)
        (state == lsb_idle) == fifo_empty);

    a_mode_kind: assert property (@(posedge clk) disable iff (resetn)
        !fifo_empty |-> (tail_elem.wr == (state == lsb_stores)));
endmodule

// ==== design/access_align.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module access_align (
    input  logic                 clk,
    input  logic                 resetn,
    input  mem_pkg::cpu_req_t    cpu_req,
    output mem_pkg::cpu_resp_t   cpu_resp,
    output mem_pkg::sramx_req_t  s_req,
    input  mem_pkg::sramx_resp_t s_resp
);
    import mem_pkg::*;

    localparam int QDEPTH = `LSB_DEPTH + `MEM_LATENCY;
    localparam int QW     = $clog2(QDEPTH);

    typedef struct packed {
        mem_op_e    op;
        logic [1:0] off;
    } ld_tag_t;

    ld_tag_t       tag_q [QDEPTH];
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [QW:0]   count;

    logic        is_store;
    logic        q_empty;
    logic        q_full;
    logic        ld_acc;
    logic        st_acc;
    logic        ld_done;
    logic [1:0]  off;
    ld_tag_t     cur_tag;
    ld_tag_t     fmt_tag;
    logic [31:0] lane;

    assign off      = cpu_req.addr[1:0];
    assign is_store = cpu_req.op inside {op_sb, op_sh, op_sw};
    assign q_empty  = (count == '0);
    assign q_full   = (count == (QW + 1)'(QDEPTH));
    assign ld_acc   = s_req.req && !is_store && s_resp.addr_ok;
    assign st_acc   = s_req.req && is_store && s_resp.addr_ok;
    assign ld_done  = s_resp.data_ok && !st_acc;   // Store completions land in their accept cycle.

    assign cur_tag.op  = cpu_req.op;
    assign cur_tag.off = off;
    assign fmt_tag     = q_empty ? cur_tag : tag_q[rd_ptr];

    always_comb begin
        s_req       = '0;
        s_req.req   = cpu_req.valid && !(!is_store && q_full);
        s_req.wr    = is_store;
        s_req.addr  = {cpu_req.addr[31:2], 2'b00};
        case (cpu_req.op)
            op_lb, op_lbu, op_sb: begin
                s_req.strb  = 4'b0001 << off;
                s_req.wdata = {4{cpu_req.wdata[7:0]}};
            end
            op_lh, op_lhu, op_sh: begin
                s_req.strb  = off[1] ? 4'b1100 : 4'b0011;
                s_req.wdata = {2{cpu_req.wdata[15:0]}};
            end
            default: begin
                s_req.strb  = 4'b1111;
                s_req.wdata = cpu_req.wdata;
            end
        endcase
    end

    always_comb begin
        lane             = s_resp.rdata >> {fmt_tag.off, 3'b000};
        cpu_resp.addr_ok = s_req.req && s_resp.addr_ok;
        cpu_resp.data_ok = s_resp.data_ok;
        case (fmt_tag.op)
            op_lb:   cpu_resp.rdata = {{24{lane[7]}}, lane[7:0]};
            op_lbu:  cpu_resp.rdata = {24'b0, lane[7:0]};
            op_lh:   cpu_resp.rdata = {{16{lane[15]}}, lane[15:0]};
            op_lhu:  cpu_resp.rdata = {16'b0, lane[15:0]};
            default: cpu_resp.rdata = s_resp.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ld_acc)
                wr_ptr <= (wr_ptr == QW'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (ld_done)
                rd_ptr <= (rd_ptr == QW'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (QW + 1)'(ld_acc) - (QW + 1)'(ld_done);
        end
    end

    always_ff @(posedge clk) begin
        if (ld_acc)
            tag_q[wr_ptr] <= cur_tag;
    end

    // Every load completion must match a recorded load.
    a_done_has_tag: assert property (@(posedge clk) disable iff (resetn)
        ld_done |-> !q_empty || ld_acc);

    a_half_aligned: assert property (@(posedge clk) disable iff (resetn)
        cpu_req.valid && (cpu_req.op inside {op_lh, op_lhu, op_sh}) |-> !cpu_req.addr[0]);
endmodule

// ==== design/mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        lsb_idle,
        lsb_loads,   // Queue holds reads only.
        lsb_stores   // Queue holds writes only.
    } lsb_state_e;

    typedef logic [$clog2(`MEM_WORDS)-1:0] word_addr_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;   // Byte address.
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic        req;
        logic        wr;
        logic [3:0]  strb;
        logic [31:0] addr;   // Word aligned.
        logic [31:0] wdata;
    } sramx_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } sramx_resp_t;

endpackage

// ==== design/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Load/store buffer entries.
`define LSB_DEPTH 4

// SRAM size in 32-bit words.
`define MEM_WORDS 256

// Cycles from acceptance to data_ok in the SRAM controller.
`define MEM_LATENCY 3

`endif
